/* project.f */
+incdir+src
src/sample_fifo_pkg.sv
src/generic_dual_port_ram.sv
src/fifo_write_control.sv
src/fifo_read_control.sv
src/async_sample_fifo.sv
verification/async_sample_fifo_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the async sample FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG_FILE=sim.log
BUILD_DIR=obj_dir

if ! verilator --binary --timing --assert \
        --top-module async_sample_fifo_tb \
        --Mdir "$BUILD_DIR" \
        -f project.f; then
    echo "Verilator build failed"
    exit 1
fi

if ! "./$BUILD_DIR/Vasync_sample_fifo_tb" > "$LOG_FILE" 2>&1; then
    cat "$LOG_FILE"
    echo "Simulation exited with an error status"
    exit 1
fi

cat "$LOG_FILE"

# The log decides the result
if grep -q "TESTS FAILED" "$LOG_FILE"; then
    exit 1
fi

exit 0

/* src/async_sample_fifo.sv */
`default_nettype none

`include "sample_fifo_params.svh"

module async_sample_fifo (
    input  wire                       write_clock,
    input  wire                       write_reset_n,
    input  wire                       write_enable,
    input  wire sample_fifo_pkg::sample_t write_data,
    input  wire                       read_clock,
    input  wire                       read_reset_n,
    input  wire                       read_request,
    output logic                      full,
    output logic                      empty,
    output logic                      read_valid,
    output sample_fifo_pkg::sample_t  read_data
);

    localparam int FIFO_DEPTH = 1 << `FIFO_DEPTH_LOG2;

    // Write domain
    logic                      ram_write_enable;
    sample_fifo_pkg::address_t ram_write_address;
    sample_fifo_pkg::pointer_t write_pointer_gray;

    // Read domain
    sample_fifo_pkg::address_t ram_read_address;
    sample_fifo_pkg::pointer_t read_pointer_gray;

    ////////////////////////////////////////////////////////////
    // Controllers
    ////////////////////////////////////////////////////////////

    fifo_write_control write_control (
        .write_clock        (write_clock),
        .write_reset_n      (write_reset_n),
        .write_enable       (write_enable),
        .read_pointer_gray  (read_pointer_gray),
        .full               (full),
        .ram_write_enable   (ram_write_enable),
        .ram_write_address  (ram_write_address),
        .write_pointer_gray (write_pointer_gray)
    );

    fifo_read_control read_control (
        .read_clock         (read_clock),
        .read_reset_n       (read_reset_n),
        .read_request       (read_request),
        .write_pointer_gray (write_pointer_gray),
        .empty              (empty),
        .read_valid         (read_valid),
        .ram_read_address   (ram_read_address),
        .read_pointer_gray  (read_pointer_gray)
    );

    ////////////////////////////////////////////////////////////
    // Sample storage
    ////////////////////////////////////////////////////////////

    generic_dual_port_ram #(
        .DATA_WIDTH       (`FIFO_DATA_WIDTH),
        .DATA_DEPTH       (FIFO_DEPTH),
        .PIPELINED_OUTPUT (`FIFO_PIPELINED_OUTPUT)
    ) sample_ram (
        .write_clock   (write_clock),
        .write_reset_n (write_reset_n),
        .write_enable  (ram_write_enable),
        .write_data    (write_data),
        .write_address (ram_write_address),
        .read_clock    (read_clock),
        .read_reset_n  (read_reset_n),
        .read_address  (ram_read_address),
        .read_data     (read_data)
    );

endmodule

`default_nettype wire

/* src/fifo_read_control.sv */
`default_nettype none

`include "sample_fifo_params.svh"

module fifo_read_control (
    input  wire                       read_clock,
    input  wire                       read_reset_n,
    input  wire                       read_request,
    input  wire sample_fifo_pkg::pointer_t write_pointer_gray,
    output logic                      empty,
    output logic                      read_valid,
    output sample_fifo_pkg::address_t ram_read_address,
    output sample_fifo_pkg::pointer_t read_pointer_gray
);

    localparam int READ_LATENCY = `FIFO_READ_LATENCY;

    sample_fifo_pkg::pointer_t read_pointer_binary;
    sample_fifo_pkg::pointer_t read_pointer_next;
    sample_fifo_pkg::pointer_t write_pointer_gray_meta;
    sample_fifo_pkg::pointer_t write_pointer_gray_sync;
    logic                      read_accept;
    logic [READ_LATENCY-1:0]   valid_pipeline;

    ////////////////////////////////////////////////////////////
    // Write pointer into the read domain
    ////////////////////////////////////////////////////////////

    always_ff @(posedge read_clock or negedge read_reset_n) begin
        if (!read_reset_n) begin
            write_pointer_gray_meta <= '0;
            write_pointer_gray_sync <= '0;
        end else begin
            write_pointer_gray_meta <= write_pointer_gray;
            write_pointer_gray_sync <= write_pointer_gray_meta;
        end
    end

    // Pointers equal including the wrap bit
    assign empty = (read_pointer_gray == write_pointer_gray_sync);

    ////////////////////////////////////////////////////////////
    // Read pointer
    ////////////////////////////////////////////////////////////

    // Requests against an empty FIFO are ignored
    assign read_accept       = read_request && !empty;
    assign read_pointer_next = read_pointer_binary +
                               sample_fifo_pkg::pointer_t'(read_accept);

    always_ff @(posedge read_clock or negedge read_reset_n) begin
        if (!read_reset_n) begin
            read_pointer_binary <= '0;
            read_pointer_gray   <= '0;
        end else begin
            read_pointer_binary <= read_pointer_next;
            read_pointer_gray   <= sample_fifo_pkg::binary_to_gray(read_pointer_next);
        end
    end

    // RAM samples this on the accepting edge, before the pointer moves
    assign ram_read_address = read_pointer_binary[`FIFO_DEPTH_LOG2-1:0];

    ////////////////////////////////////////////////////////////
    // Valid pulse matching the RAM read latency
    ////////////////////////////////////////////////////////////

    always_ff @(posedge read_clock or negedge read_reset_n) begin
        if (!read_reset_n) begin
            valid_pipeline <= '0;
        end else begin
            valid_pipeline[0] <= read_accept;
            for (int stage = 1; stage < READ_LATENCY; stage++) begin
                valid_pipeline[stage] <= valid_pipeline[stage-1];
            end
        end
    end

    assign read_valid = valid_pipeline[READ_LATENCY-1];

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    pointer_held_while_empty : assert property (
        @(posedge read_clock) disable iff (!read_reset_n)
        empty |=> $stable(read_pointer_binary)
    );

endmodule

`default_nettype wire

/* src/fifo_write_control.sv */
`default_nettype none

`include "sample_fifo_params.svh"

module fifo_write_control (
    input  wire                       write_clock,
    input  wire                       write_reset_n,
    input  wire                       write_enable,
    input  wire sample_fifo_pkg::pointer_t read_pointer_gray,
    output logic                      full,
    output logic                      ram_write_enable,
    output sample_fifo_pkg::address_t ram_write_address,
    output sample_fifo_pkg::pointer_t write_pointer_gray
);

    // Flips the wrap bit and the top address bit of a Gray pointer
    localparam sample_fifo_pkg::pointer_t FULL_MASK =
        sample_fifo_pkg::pointer_t'(3) << (`FIFO_DEPTH_LOG2 - 1);

    sample_fifo_pkg::pointer_t write_pointer_binary;
    sample_fifo_pkg::pointer_t write_pointer_next;
    sample_fifo_pkg::pointer_t read_pointer_gray_meta;
    sample_fifo_pkg::pointer_t read_pointer_gray_sync;

    ////////////////////////////////////////////////////////////
    // Write pointer
    ////////////////////////////////////////////////////////////

    // Writes while full are dropped here
    assign ram_write_enable   = write_enable && !full;
    assign write_pointer_next = write_pointer_binary +
                                sample_fifo_pkg::pointer_t'(ram_write_enable);

    // Gray copy taken from the next value so both stay aligned
    always_ff @(posedge write_clock or negedge write_reset_n) begin
        if (!write_reset_n) begin
            write_pointer_binary <= '0;
            write_pointer_gray   <= '0;
        end else begin
            write_pointer_binary <= write_pointer_next;
            write_pointer_gray   <= sample_fifo_pkg::binary_to_gray(write_pointer_next);
        end
    end

    assign ram_write_address = write_pointer_binary[`FIFO_DEPTH_LOG2-1:0];

    ////////////////////////////////////////////////////////////
    // Read pointer into the write domain
    ////////////////////////////////////////////////////////////

    always_ff @(posedge write_clock or negedge write_reset_n) begin
        if (!write_reset_n) begin
            read_pointer_gray_meta <= '0;
            read_pointer_gray_sync <= '0;
        end else begin
            read_pointer_gray_meta <= read_pointer_gray;
            read_pointer_gray_sync <= read_pointer_gray_meta;
        end
    end

    // Full when the writer is one lap ahead of the reader
    assign full = (write_pointer_gray == (read_pointer_gray_sync ^ FULL_MASK));

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    no_write_while_full : assert property (
        @(posedge write_clock) disable iff (!write_reset_n)
        full |-> !ram_write_enable
    );

endmodule

`default_nettype wire

/* src/generic_dual_port_ram.sv */
`default_nettype none

module generic_dual_port_ram #(
    parameter int DATA_WIDTH       = 16,
    parameter int DATA_DEPTH       = 4096,
    parameter int PIPELINED_OUTPUT = 1
) (
    input  wire                          write_clock,
    input  wire                          write_reset_n,
    input  wire                          write_enable,
    input  wire [DATA_WIDTH-1:0]         write_data,
    input  wire [$clog2(DATA_DEPTH)-1:0] write_address,
    input  wire                          read_clock,
    input  wire                          read_reset_n,
    input  wire [$clog2(DATA_DEPTH)-1:0] read_address,
    output logic [DATA_WIDTH-1:0]        read_data
);

    ////////////////////////////////////////////////////////////
    // Storage and write port
    ////////////////////////////////////////////////////////////

    logic [DATA_WIDTH-1:0] memory [DATA_DEPTH];

    // Whole array cleared so unwritten entries read back as zero
    always_ff @(posedge write_clock or negedge write_reset_n) begin
        if (!write_reset_n) begin
            for (int entry = 0; entry < DATA_DEPTH; entry++) begin
                memory[entry] <= '0;
            end
        end else if (write_enable) begin
            memory[write_address] <= write_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // Registered read port
    ////////////////////////////////////////////////////////////

    logic [DATA_WIDTH-1:0] memory_read_data;

    // First stage samples the array every read_clock edge
    always_ff @(posedge read_clock or negedge read_reset_n) begin
        if (!read_reset_n) begin
            memory_read_data <= '0;
        end else begin
            memory_read_data <= memory[read_address];
        end
    end

    generate
        if (PIPELINED_OUTPUT != 0) begin : g_output_register
            logic [DATA_WIDTH-1:0] pipelined_read_data;

            // Extra stage for timing closure on wide arrays
            always_ff @(posedge read_clock or negedge read_reset_n) begin
                if (!read_reset_n) begin
                    pipelined_read_data <= '0;
                end else begin
                    pipelined_read_data <= memory_read_data;
                end
            end

            assign read_data = pipelined_read_data;
        end else begin : g_direct_output
            assign read_data = memory_read_data;
        end
    endgenerate

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    // Writes land inside the array
    write_address_in_range : assert property (
        @(posedge write_clock) disable iff (!write_reset_n)
        write_enable |-> (int'(write_address) < DATA_DEPTH)
    );

endmodule

`default_nettype wire

/* src/sample_fifo_params.svh */
`ifndef SAMPLE_FIFO_PARAMS_SVH
`define SAMPLE_FIFO_PARAMS_SVH

// Width of one sensor sample
`define FIFO_DATA_WIDTH 16

// Log2 of the number of FIFO entries
`define FIFO_DEPTH_LOG2 4

// 1 adds the second RAM output register
`define FIFO_PIPELINED_OUTPUT 1

// Read clock cycles from an accepted read to read_valid
`define FIFO_READ_LATENCY (1 + `FIFO_PIPELINED_OUTPUT)

`endif

/* src/sample_fifo_pkg.sv */
`default_nettype none

`include "sample_fifo_params.svh"

package sample_fifo_pkg;

    // One sample as stored in the RAM
    typedef logic [`FIFO_DATA_WIDTH-1:0] sample_t;

    // RAM address, no wrap bit
    typedef logic [`FIFO_DEPTH_LOG2-1:0] address_t;

    // Binary or Gray pointer, top bit marks the wrap
    typedef logic [`FIFO_DEPTH_LOG2:0] pointer_t;

    // Binary to reflected Gray code
    function automatic pointer_t binary_to_gray(input pointer_t binary_value);
        return binary_value ^ (binary_value >> 1);
    endfunction

endpackage

`default_nettype wire

/* verification/async_sample_fifo_tb.sv */
`default_nettype none

`include "sample_fifo_params.svh"

module async_sample_fifo_tb;

    localparam int DEPTH   = 1 << `FIFO_DEPTH_LOG2;
    localparam int LATENCY = `FIFO_READ_LATENCY;

    // Rough length of each test in read_clock cycles, reset first
    localparam int TOTAL_TEST_CYCLES = 10 + 20 + 60 + 120 + 60 + 460;
    localparam int WATCHDOG_TIME     = TOTAL_TEST_CYCLES * 10 + 2000;

    logic                     write_clock;
    logic                     write_reset_n;
    logic                     write_enable;
    sample_fifo_pkg::sample_t write_data;
    logic                     read_clock;
    logic                     read_reset_n;
    logic                     read_request;
    wire                      full;
    wire                      empty;
    wire                      read_valid;
    wire sample_fifo_pkg::sample_t read_data;

    // Reference model, indexed by read position
    sample_fifo_pkg::sample_t written_log[$];
    sample_fifo_pkg::sample_t received_log[$];
    int                       accept_cycles[$];
    int                       read_cycle = 0;

    int          monitor_errors = 0;
    int          test_errors    = 0;
    int          pass_count     = 0;
    int          fail_count     = 0;
    int unsigned write_lcg      = 24103;
    int unsigned read_lcg       = 24103;
    logic        stream_done;

    async_sample_fifo uut (
        .write_clock   (write_clock),
        .write_reset_n (write_reset_n),
        .write_enable  (write_enable),
        .write_data    (write_data),
        .read_clock    (read_clock),
        .read_reset_n  (read_reset_n),
        .read_request  (read_request),
        .full          (full),
        .empty         (empty),
        .read_valid    (read_valid),
        .read_data     (read_data)
    );

    initial begin
        read_clock = 1'b0;
        forever #5 read_clock = ~read_clock;
    end

    initial begin
        write_clock = 1'b0;
        forever #7 write_clock = ~write_clock;
    end

    always @(posedge read_clock) begin
        read_cycle++;
    end

    ////////////////////////////////////////////////////////////
    // Monitors, sampled on the falling edge
    ////////////////////////////////////////////////////////////

    // Next write_clock edge accepts when this holds
    always @(negedge write_clock) begin
        if (write_reset_n && write_enable && !full) begin
            written_log.push_back(write_data);
        end
    end

    always @(negedge read_clock) begin : read_monitor
        int expected_cycle;
        int position;
        if (read_reset_n) begin
            // The next rising edge is read_cycle + 1
            if (accept_cycles.size() > 0 && accept_cycles[0] + LATENCY < read_cycle + 1) begin
                $display("read_valid missing at %0t for the read accepted at cycle %0d",
                         $time, accept_cycles[0]);
                monitor_errors++;
                void'(accept_cycles.pop_front());
            end
            if (read_valid) begin
                position = received_log.size();
                received_log.push_back(read_data);
                if (accept_cycles.size() == 0) begin
                    $display("read_valid at %0t without any accepted read", $time);
                    monitor_errors++;
                end else begin
                    expected_cycle = accept_cycles.pop_front() + LATENCY;
                    if (read_cycle + 1 != expected_cycle) begin
                        show_mismatch("read_valid cycle", expected_cycle, read_cycle + 1);
                        monitor_errors++;
                    end
                end
                if (position >= written_log.size()) begin
                    $display("read_valid at %0t with no written sample left", $time);
                    monitor_errors++;
                end else if (read_data !== written_log[position]) begin
                    show_mismatch("read_data", 32'(written_log[position]), 32'(read_data));
                    monitor_errors++;
                end
            end
            if (read_request && !empty) begin
                accept_cycles.push_back(read_cycle + 1);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic int unsigned lcg_next(input int unsigned state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic void show_mismatch(input string name, input int unsigned expected,
                                          input int unsigned actual);
        $display("error at %0t: %s expected %0h, actual %0h", $time, name, expected, actual);
    endfunction

    task automatic finish_test(input string name, input int errors_before);
        if (test_errors + monitor_errors == errors_before) begin
            pass_count++;
            $display("test %s: pass", name);
        end else begin
            fail_count++;
            $display("test %s: fail", name);
        end
    endtask

    // One write_clock cycle of write_enable
    task automatic write_sample(input sample_fifo_pkg::sample_t value);
        @(posedge write_clock);
        #1;
        write_enable = 1'b1;
        write_data   = value;
        @(posedge write_clock);
        #1;
        write_enable = 1'b0;
    endtask

    task automatic wait_for_level(input string name, input logic level, input int max_cycles);
        int cycles;
        cycles = 0;
        while (((name == "empty") ? empty : full) !== level && cycles < max_cycles) begin
            @(posedge read_clock);
            #1;
            cycles++;
        end
        if (((name == "empty") ? empty : full) !== level) begin
            $display("%s did not reach %0b within %0d read clock cycles", name, level, max_cycles);
            test_errors++;
        end
    endtask

    // Reads until empty has stayed high long enough for the pointer sync
    task automatic drain_fifo();
        int idle_cycles;
        idle_cycles = 0;
        @(posedge read_clock);
        #1;
        read_request = 1'b1;
        while (idle_cycles < 8) begin
            @(posedge read_clock);
            #1;
            if (empty) begin
                idle_cycles++;
            end else begin
                idle_cycles = 0;
            end
        end
        read_request = 1'b0;
        repeat (LATENCY + 2) @(posedge read_clock);
        #1;
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    task automatic check_reset_values();
        int errors_before;
        errors_before = test_errors + monitor_errors;
        @(posedge read_clock);
        #1;
        if (empty !== 1'b1) begin
            show_mismatch("empty", 1, 32'(empty));
            test_errors++;
        end
        if (full !== 1'b0) begin
            show_mismatch("full", 0, 32'(full));
            test_errors++;
        end
        if (read_valid !== 1'b0) begin
            show_mismatch("read_valid", 0, 32'(read_valid));
            test_errors++;
        end
        if (read_data !== '0) begin
            show_mismatch("read_data", 0, 32'(read_data));
            test_errors++;
        end
        finish_test("reset values", errors_before);
    endtask

    task automatic check_order_and_latency();
        int                       errors_before;
        int                       start;
        sample_fifo_pkg::sample_t values[5];
        errors_before = test_errors + monitor_errors;
        start = received_log.size();
        for (int i = 0; i < 5; i++) begin
            values[i] = sample_fifo_pkg::sample_t'(16'h1100 + i * 16'h0111);
            write_sample(values[i]);
        end
        wait_for_level("empty", 1'b0, 20);
        // Let the last write pointer update cross the synchronizer
        repeat (4) @(posedge read_clock);
        #1;
        read_request = 1'b1;
        repeat (5) begin
            @(posedge read_clock);
            #1;
        end
        read_request = 1'b0;
        repeat (LATENCY + 2) @(posedge read_clock);
        #1;
        if (received_log.size() - start != 5) begin
            show_mismatch("read_valid count", 5, received_log.size() - start);
            test_errors++;
        end else begin
            for (int i = 0; i < 5; i++) begin
                if (received_log[start + i] !== values[i]) begin
                    show_mismatch("read_data", 32'(values[i]), 32'(received_log[start + i]));
                    test_errors++;
                end
            end
        end
        if (empty !== 1'b1) begin
            show_mismatch("empty", 1, 32'(empty));
            test_errors++;
        end
        finish_test("order and latency", errors_before);
    endtask

    task automatic check_full_and_dropped_writes();
        int                       errors_before;
        int                       start;
        sample_fifo_pkg::sample_t values[$];
        errors_before = test_errors + monitor_errors;
        start = received_log.size();
        for (int i = 0; i < DEPTH; i++) begin
            write_lcg = lcg_next(write_lcg);
            values.push_back(sample_fifo_pkg::sample_t'(write_lcg >> 8));
            write_sample(values[i]);
        end
        wait_for_level("full", 1'b1, 10);
        // These three land on a full FIFO
        write_sample(16'hdead);
        write_sample(16'hbeef);
        write_sample(16'hcafe);
        drain_fifo();
        if (received_log.size() - start != DEPTH) begin
            show_mismatch("read_valid count", DEPTH, received_log.size() - start);
            test_errors++;
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (received_log[start + i] !== values[i]) begin
                    show_mismatch("read_data", 32'(values[i]), 32'(received_log[start + i]));
                    test_errors++;
                end
            end
        end
        finish_test("full and dropped writes", errors_before);
    endtask

    task automatic check_read_while_empty();
        int errors_before;
        int start;
        errors_before = test_errors + monitor_errors;
        start = received_log.size();
        if (empty !== 1'b1) begin
            show_mismatch("empty", 1, 32'(empty));
            test_errors++;
        end
        @(posedge read_clock);
        #1;
        read_request = 1'b1;
        repeat (6) @(posedge read_clock);
        #1;
        read_request = 1'b0;
        repeat (LATENCY + 2) @(posedge read_clock);
        #1;
        if (received_log.size() != start) begin
            $display("read_valid appeared while the FIFO was empty");
            test_errors++;
        end
        write_sample(16'h5a3c);
        wait_for_level("empty", 1'b0, 20);
        drain_fifo();
        if (received_log.size() - start != 1) begin
            show_mismatch("read_valid count", 1, received_log.size() - start);
            test_errors++;
        end else if (received_log[start] !== 16'h5a3c) begin
            show_mismatch("read_data", 32'h5a3c, 32'(received_log[start]));
            test_errors++;
        end
        finish_test("read while empty", errors_before);
    endtask

    task automatic check_concurrent_streaming();
        int errors_before;
        int start;
        errors_before = test_errors + monitor_errors;
        start = received_log.size();
        stream_done = 1'b0;
        fork
            begin
                // Writer runs faster than the reader, so full is reached
                while (!stream_done) begin
                    @(posedge write_clock);
                    #1;
                    write_lcg    = lcg_next(write_lcg);
                    write_enable = (write_lcg[23:21] != 3'b000);
                    write_data   = sample_fifo_pkg::sample_t'(write_lcg >> 8);
                end
                write_enable = 1'b0;
            end
            begin
                repeat (400) begin
                    @(posedge read_clock);
                    #1;
                    read_lcg     = lcg_next(read_lcg);
                    read_request = read_lcg[22];
                end
                read_request = 1'b0;
                stream_done  = 1'b1;
            end
        join
        drain_fifo();
        if (received_log.size() != written_log.size()) begin
            show_mismatch("samples read", written_log.size(), received_log.size());
            test_errors++;
        end
        if (received_log.size() == start) begin
            $display("no samples were read during the streaming test");
            test_errors++;
        end
        finish_test("concurrent streaming", errors_before);
    endtask

    ////////////////////////////////////////////////////////////
    // Sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        write_enable  = 1'b0;
        write_data    = '0;
        read_request  = 1'b0;
        write_reset_n = 1'b0;
        read_reset_n  = 1'b0;
        stream_done   = 1'b0;
        repeat (4) @(posedge read_clock);
        #1;
        write_reset_n = 1'b1;
        read_reset_n  = 1'b1;

        check_reset_values();
        check_order_and_latency();
        check_full_and_dropped_writes();
        check_read_while_empty();
        check_concurrent_streaming();

        $display("tests passing %0d, tests failing %0d", pass_count, fail_count);
        if (fail_count == 0 && test_errors == 0 && monitor_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("timeout: the tests did not finish within %0d time units", WATCHDOG_TIME);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
